/* src/rename_pkg.sv */
// ####################################################################
// Rename stage package.
// Register file sizes and the structs that cross the stage boundary:
// dispatch request and response, result bus and retirement.
// ####################################################################

package rename_pkg;

  localparam int NUM_AREGS  = 32;  // Architectural registers.
  localparam int NUM_PREGS  = 64;  // Physical registers.
  localparam int AREG_W     = 5;   // Architectural index width.
  localparam int PREG_W     = 6;   // Physical tag width.
  localparam int FREE_DEPTH = NUM_PREGS - NUM_AREGS;  // Free tags when idle.
  localparam int CNT_W      = 6;   // Holds 0 to FREE_DEPTH.

  // One dispatch request from the decoder.
  typedef struct packed {
    logic [AREG_W-1:0] opa_areg;   // Operand A source.
    logic [AREG_W-1:0] opb_areg;   // Operand B source.
    logic [AREG_W-1:0] dest_areg;  // Destination.
    logic              dest_wr;    // Instruction writes a register.
  } rename_req_t;

  // Rename result for the request above.
  typedef struct packed {
    logic [PREG_W-1:0] opa_preg;
    logic              opa_rdy;
    logic [PREG_W-1:0] opb_preg;
    logic              opb_rdy;
    logic [PREG_W-1:0] new_preg;   // Tag taken from the free list.
    logic [PREG_W-1:0] old_preg;   // Previous destination tag, kept by the ROB.
  } rename_rsp_t;

  // Common data bus broadcast.
  typedef struct packed {
    logic              valid;
    logic [PREG_W-1:0] preg;       // Tag whose value is now ready.
  } cdb_t;

  // One retiring instruction.
  typedef struct packed {
    logic              valid;
    logic [AREG_W-1:0] dest_areg;
    logic [PREG_W-1:0] new_preg;   // Becomes the committed mapping.
    logic [PREG_W-1:0] old_preg;   // Returned to the free list.
  } retire_t;

endpackage

/* src/map_table.sv */
// ####################################################################
// Speculative map table.
// Architectural to physical tag map with a ready bit per register.
// Three combinational reads, one rename write, result bus wakeup and
// a single cycle restore from the retirement map.
// ####################################################################

module map_table (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  rename_pkg::rename_req_t                                  req_i,
  input  logic                                                     alloc_en_i,
  input  logic [rename_pkg::PREG_W-1:0]                            new_preg_i,
  input  rename_pkg::cdb_t                                         cdb_i,
  input  logic                                                     restore_en_i,
  input  logic [rename_pkg::NUM_AREGS-1:0][rename_pkg::PREG_W-1:0] arch_tags_i,
  output rename_pkg::rename_rsp_t                                  rsp_map_o
);

  import rename_pkg::*;

  logic [NUM_AREGS-1:0][PREG_W-1:0] map_q;
  logic [NUM_AREGS-1:0]             rdy_q;
  logic [NUM_AREGS-1:0]             cdb_hit;   // Registers holding the broadcast tag.
  logic [NUM_AREGS-1:0]             rdy_next;

  // Tag search across the whole map.
  always_comb begin
    for (int i = 0; i < NUM_AREGS; i++) begin
      cdb_hit[i] = cdb_i.valid && (map_q[i] == cdb_i.preg);
    end
  end

  // Wakeup first, then the rename clears its own bit.
  always_comb begin
    rdy_next = rdy_q | cdb_hit;
    if (alloc_en_i) begin
      rdy_next[req_i.dest_areg] = 1'b0;  // Rename beats a same cycle broadcast.
    end
  end

  // Read ports.
  always_comb begin
    rsp_map_o          = '0;
    rsp_map_o.opa_preg = map_q[req_i.opa_areg];
    rsp_map_o.opb_preg = map_q[req_i.opb_areg];
    // Broadcast bypass so an operand woken this cycle reads ready.
    rsp_map_o.opa_rdy  = rdy_q[req_i.opa_areg] | cdb_hit[req_i.opa_areg];
    rsp_map_o.opb_rdy  = rdy_q[req_i.opb_areg] | cdb_hit[req_i.opb_areg];
    rsp_map_o.old_preg = map_q[req_i.dest_areg];  // Goes to the ROB.
    rsp_map_o.new_preg = '0;                      // Filled in from the free list.
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        map_q[i] <= PREG_W'(i);  // Identity map.
      end
      rdy_q <= '1;
    end else if (restore_en_i) begin
      map_q <= arch_tags_i;      // Committed state, all values exist.
      rdy_q <= '1;
    end else begin
      if (alloc_en_i) begin
        map_q[req_i.dest_areg] <= new_preg_i;
      end
      rdy_q <= rdy_next;
    end
  end

  // Recovery and dispatch come from separate FSM states.
  a_restore_alloc_excl: assert property (
    @(posedge clk) disable iff (rst) !(restore_en_i && alloc_en_i))
    else $error("map_table: restore and allocation in the same cycle");

endmodule

/* src/arch_map.sv */
// ####################################################################
// Retirement map.
// Committed architectural to physical mapping, written on retire and
// read whole by the speculative map on recovery.
// ####################################################################

module arch_map (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  rename_pkg::retire_t                                      retire_i,
  output logic [rename_pkg::NUM_AREGS-1:0][rename_pkg::PREG_W-1:0] arch_tags_o
);

  import rename_pkg::*;

  logic [NUM_AREGS-1:0][PREG_W-1:0] tags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        tags_q[i] <= PREG_W'(i);
      end
    end else if (retire_i.valid) begin
      tags_q[retire_i.dest_areg] <= retire_i.new_preg;  // Commit.
    end
  end

  // Write through, so a restore in a retiring cycle sees the new commit.
  always_comb begin
    arch_tags_o = tags_q;
    if (retire_i.valid) begin
      arch_tags_o[retire_i.dest_areg] = retire_i.new_preg;
    end
  end

endmodule

/* src/free_list.sv */
// ####################################################################
// Free list.
// Circular store of free physical tags. Head hands out tags, tail
// takes back tags freed at retire. Rewind moves head onto tail.
// ####################################################################

module free_list (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          pop_i,
  input  logic                          push_i,
  input  logic [rename_pkg::PREG_W-1:0] push_preg_i,
  input  logic                          rewind_i,
  output logic [rename_pkg::PREG_W-1:0] head_preg_o
);

  import rename_pkg::*;

  typedef logic [$clog2(FREE_DEPTH)-1:0] ptr_t;

  logic [FREE_DEPTH-1:0][PREG_W-1:0] slots_q;
  ptr_t                              head_q;     // Next tag to allocate.
  ptr_t                              tail_q;     // Next slot for a freed tag.
  ptr_t                              tail_next;

  // Occupancy lives in free_count, so head == tail is both full and empty.
  assign tail_next   = push_i ? tail_q + ptr_t'(1) : tail_q;
  assign head_preg_o = slots_q[head_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < FREE_DEPTH; k++) begin
        slots_q[k] <= PREG_W'(NUM_AREGS + k);  // Tags above the identity map.
      end
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (push_i) begin
        slots_q[tail_q] <= push_preg_i;
      end
      tail_q <= tail_next;
      // Slots from tail to head still hold the tags taken since the
      // last retire, in order. Moving head back returns all of them.
      if (rewind_i) begin
        head_q <= tail_next;
      end else if (pop_i) begin
        head_q <= head_q + ptr_t'(1);
      end
    end
  end

  // During rewind the head moves to the tail only, never by an allocation.
  a_head_rewind_only: assert property (
    @(posedge clk) disable iff (rst) rewind_i |-> !pop_i)
    else $error("free_list: allocation during rewind");

endmodule

/* src/free_count.sv */
// ####################################################################
// Free list occupancy counter.
// Counts free tags from 0 to FREE_DEPTH and flags empty.
// ####################################################################

module free_count (
  input  logic clk,
  input  logic rst,
  input  logic inc_i,     // Tag returned at retire.
  input  logic dec_i,     // Tag allocated.
  input  logic reload_i,  // Recovery.
  output logic empty_o
);

  import rename_pkg::*;

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= CNT_W'(FREE_DEPTH);
    end else if (reload_i) begin
      count_q <= CNT_W'(FREE_DEPTH);     // Every uncommitted tag is free again.
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + CNT_W'(1);
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - CNT_W'(1);
    end
  end

  assign empty_o = (count_q == '0);

  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst) dec_i |-> !empty_o)
    else $error("free_count: allocation from an empty list");

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst) (inc_i && !dec_i) |-> (count_q != CNT_W'(FREE_DEPTH)))
    else $error("free_count: retire into a full list");

endmodule

/* src/rename_ctrl.sv */
// ####################################################################
// Rename control FSM.
// Gates dispatch on state, flush and free list empty, and runs the
// one cycle recovery that restores the map and rewinds the list.
// ####################################################################

module rename_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic req_valid_i,
  input  logic dest_wr_i,
  input  logic flush_i,      // One cycle pulse from the ROB.
  input  logic empty_i,      // No free tag left.
  output logic req_ready_o,
  output logic alloc_en_o,
  output logic restore_en_o
);

  typedef enum logic [1:0] {
    RESET,
    RUN,
    RECOVER
  } state_e;

  state_e state_q;
  state_e state_next;

  always_comb begin
    state_next = state_q;
    case (state_q)
      RESET:   state_next = RUN;
      RUN:     if (flush_i) state_next = RECOVER;
      RECOVER: state_next = flush_i ? RECOVER : RUN;  // Back to back flush restores again.
      default: state_next = RESET;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RESET;
    end else begin
      state_q <= state_next;
    end
  end

  // No dispatch in the flush cycle, since that request is squashed.
  assign req_ready_o  = (state_q == RUN) && !flush_i && !empty_i;
  assign alloc_en_o   = req_valid_i && req_ready_o && dest_wr_i;
  assign restore_en_o = (state_q == RECOVER);

endmodule

/* src/rename_unit.sv */
// ####################################################################
// Register rename stage.
// Renames one instruction per cycle over a valid/ready handshake,
// wakes operands from the result bus and recovers on flush.
// ####################################################################

module rename_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid_i,
  input  rename_pkg::rename_req_t req_i,
  output logic                    req_ready_o,
  output rename_pkg::rename_rsp_t rsp_o,
  input  rename_pkg::cdb_t        cdb_i,
  input  rename_pkg::retire_t     retire_i,
  input  logic                    flush_i
);

  import rename_pkg::*;

  logic                             alloc_en;
  logic                             restore_en;
  logic                             empty;
  logic [PREG_W-1:0]                head_preg;   // Next free tag.
  logic [NUM_AREGS-1:0][PREG_W-1:0] arch_tags;
  rename_rsp_t                      rsp_map;

  rename_ctrl rename_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .dest_wr_i    (req_i.dest_wr),
    .flush_i      (flush_i),
    .empty_i      (empty),
    .req_ready_o  (req_ready_o),
    .alloc_en_o   (alloc_en),
    .restore_en_o (restore_en)
  );

  map_table map_table_inst (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .alloc_en_i   (alloc_en),
    .new_preg_i   (head_preg),
    .cdb_i        (cdb_i),
    .restore_en_i (restore_en),
    .arch_tags_i  (arch_tags),
    .rsp_map_o    (rsp_map)
  );

  arch_map arch_map_inst (
    .clk         (clk),
    .rst         (rst),
    .retire_i    (retire_i),
    .arch_tags_o (arch_tags)
  );

  free_list free_list_inst (
    .clk         (clk),
    .rst         (rst),
    .pop_i       (alloc_en),
    .push_i      (retire_i.valid),
    .push_preg_i (retire_i.old_preg),
    .rewind_i    (restore_en),
    .head_preg_o (head_preg)
  );

  free_count free_count_inst (
    .clk      (clk),
    .rst      (rst),
    .inc_i    (retire_i.valid),
    .dec_i    (alloc_en),
    .reload_i (restore_en),
    .empty_o  (empty)
  );

  // Map table answer plus the tag at the free list head.
  always_comb begin
    rsp_o          = rsp_map;
    rsp_o.new_preg = head_preg;
  end

endmodule

/* dv/tb_rename_unit.sv */
// ####################################################################
// Testbench for the register rename stage.
// Plays decoder, result bus and ROB, keeps a reference model of the
// maps and the free list, and checks the DUT with assertions.
// ####################################################################

module tb_rename_unit;

  import rename_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int N_READ  = NUM_AREGS;  // One read per register.
  localparam int N_RAND  = 40;
  localparam int N_BUS   = 8;
  localparam int N_DRAIN = FREE_DEPTH;
  localparam int N_HOLD  = 4;
  localparam int N_PRE   = 12;
  localparam int N_AFTER = 10;
  localparam int MARGIN  = 60;
  localparam int MAX_CYCLES = RESET_CYCLES + 1 + N_READ + N_RAND + N_BUS + N_DRAIN
                              + FREE_DEPTH + N_HOLD + N_PRE + 2 + N_READ + N_AFTER + MARGIN;

  typedef struct packed {
    logic [AREG_W-1:0] dest_areg;
    logic [PREG_W-1:0] new_preg;
    logic [PREG_W-1:0] old_preg;
  } rob_entry_t;

  logic        clk;
  logic        rst;
  logic        req_valid_i;
  rename_req_t req_i;
  logic        req_ready_o;
  rename_rsp_t rsp_o;
  cdb_t        cdb_i;
  retire_t     retire_i;
  logic        flush_i;

  // Reference model state.
  logic [PREG_W-1:0] m_map [NUM_AREGS];
  logic              m_rdy [NUM_AREGS];
  logic [PREG_W-1:0] m_arch [NUM_AREGS];
  logic [PREG_W-1:0] fl_slots [FREE_DEPTH];
  logic [4:0]        fl_head;   // Wraps with FREE_DEPTH.
  logic [4:0]        fl_tail;
  int                fl_count;
  logic              started;   // Out of the post reset state.
  logic              recover;   // Cycle after a flush.
  logic              last_acc;  // Request taken at the last edge.
  rob_entry_t        rob_q [$];  // In flight renames, oldest first.

  logic        exp_ready;
  rename_rsp_t exp_rsp;
  logic        handshake;
  logic [31:0] lfsr_q = 32'h43f376a9;
  int          err_count = 0;
  int          acc_count = 0;
  int          cycle_count = 0;

  rename_unit rename_unit_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .cdb_i       (cdb_i),
    .retire_i    (retire_i),
    .flush_i     (flush_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic rename_req_t make_req(input int opa, input int opb, input int dest,
                                           input logic wr);
    rename_req_t r;
    r.opa_areg  = AREG_W'(opa);
    r.opb_areg  = AREG_W'(opb);
    r.dest_areg = AREG_W'(dest);
    r.dest_wr   = wr;
    return r;
  endfunction

  function automatic rename_req_t rand_req(input logic wr);
    return make_req(int'(take_bits(AREG_W)), int'(take_bits(AREG_W)),
                    int'(take_bits(AREG_W)), wr);
  endfunction

  function automatic cdb_t make_cdb(input logic v, input logic [PREG_W-1:0] p);
    cdb_t c;
    c.valid = v;
    c.preg  = p;
    return c;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_count++;
    $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  // Called at a falling edge, returns at the next one.
  task automatic drive_cycle(input logic valid, input rename_req_t r, input cdb_t c,
                             input logic ret, input logic fl);
    req_valid_i = valid;
    req_i       = r;
    cdb_i       = c;
    flush_i     = fl;
    retire_i    = '0;
    if (ret && rob_q.size() > 0) begin
      retire_i.valid     = 1'b1;  // ROB retires its oldest entry.
      retire_i.dest_areg = rob_q[0].dest_areg;
      retire_i.new_preg  = rob_q[0].new_preg;
      retire_i.old_preg  = rob_q[0].old_preg;
    end
    @(negedge clk);
  endtask

  // Holds the request until the stage takes it.
  task automatic send(input rename_req_t r, input cdb_t c, input logic ret);
    drive_cycle(1'b1, r, c, ret, 1'b0);
    while (!last_acc) begin
      drive_cycle(1'b1, r, '0, 1'b0, 1'b0);
    end
  endtask

  // Expected outputs from the model state.
  always_comb begin
    exp_ready        = started && !recover && !flush_i && (fl_count != 0);
    exp_rsp.opa_preg = m_map[req_i.opa_areg];
    exp_rsp.opb_preg = m_map[req_i.opb_areg];
    exp_rsp.opa_rdy  = m_rdy[req_i.opa_areg] || (cdb_i.valid && cdb_i.preg == exp_rsp.opa_preg);
    exp_rsp.opb_rdy  = m_rdy[req_i.opb_areg] || (cdb_i.valid && cdb_i.preg == exp_rsp.opb_preg);
    exp_rsp.new_preg = fl_slots[fl_head];  // Next tag in list order.
    exp_rsp.old_preg = m_map[req_i.dest_areg];
  end

  assign handshake = req_valid_i && req_ready_o;

  // Model update, one step per rising edge.
  always @(posedge clk) begin : model_update
    logic              acc;
    logic [PREG_W-1:0] tag;
    if (rst) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        m_map[i]  = PREG_W'(i);
        m_rdy[i]  = 1'b1;
        m_arch[i] = PREG_W'(i);
      end
      for (int k = 0; k < FREE_DEPTH; k++) begin
        fl_slots[k] = PREG_W'(NUM_AREGS + k);  // 32 upward.
      end
      fl_head  = '0;
      fl_tail  = '0;
      fl_count = FREE_DEPTH;
      started  = 1'b0;
      recover  = 1'b0;
      last_acc = 1'b0;
      rob_q.delete();
    end else begin
      acc      = req_valid_i && exp_ready;
      tag      = fl_slots[fl_head];
      last_acc = acc;
      if (acc) acc_count++;
      if (retire_i.valid) begin  // Accepted in any cycle.
        m_arch[retire_i.dest_areg] = retire_i.new_preg;
        fl_slots[fl_tail] = retire_i.old_preg;
        fl_tail++;
        fl_count++;
        void'(rob_q.pop_front());
      end
      if (recover) begin
        for (int i = 0; i < NUM_AREGS; i++) begin
          m_map[i] = m_arch[i];
          m_rdy[i] = 1'b1;
        end
        fl_head  = fl_tail;      // Uncommitted tags come back in order.
        fl_count = FREE_DEPTH;
      end else begin
        for (int i = 0; i < NUM_AREGS; i++) begin
          if (cdb_i.valid && m_map[i] == cdb_i.preg) m_rdy[i] = 1'b1;
        end
        if (acc && req_i.dest_wr) begin  // Rename after wakeup, so it wins.
          rob_q.push_back({req_i.dest_areg, tag, m_map[req_i.dest_areg]});
          m_map[req_i.dest_areg] = tag;
          m_rdy[req_i.dest_areg] = 1'b0;
          fl_head++;
          fl_count--;
        end
      end
      if (flush_i) rob_q.delete();  // Younger renames are squashed.
      recover = flush_i;
      started = 1'b1;
    end
  end

  a_ready: assert property (@(posedge clk) disable iff (rst) req_ready_o == exp_ready)
    else report_mismatch("req_ready_o", 32'($sampled(req_ready_o)), 32'($sampled(exp_ready)));

  a_opa: assert property (@(posedge clk) disable iff (rst)
    handshake |-> {rsp_o.opa_preg, rsp_o.opa_rdy} == {exp_rsp.opa_preg, exp_rsp.opa_rdy})
    else report_mismatch("operand A tag and ready", 32'($sampled({rsp_o.opa_preg, rsp_o.opa_rdy})),
                         32'($sampled({exp_rsp.opa_preg, exp_rsp.opa_rdy})));

  a_opb: assert property (@(posedge clk) disable iff (rst)
    handshake |-> {rsp_o.opb_preg, rsp_o.opb_rdy} == {exp_rsp.opb_preg, exp_rsp.opb_rdy})
    else report_mismatch("operand B tag and ready", 32'($sampled({rsp_o.opb_preg, rsp_o.opb_rdy})),
                         32'($sampled({exp_rsp.opb_preg, exp_rsp.opb_rdy})));

  a_new: assert property (@(posedge clk) disable iff (rst)
    (handshake && req_i.dest_wr) |-> rsp_o.new_preg == exp_rsp.new_preg)
    else report_mismatch("new_preg", 32'($sampled(rsp_o.new_preg)), 32'($sampled(exp_rsp.new_preg)));

  a_old: assert property (@(posedge clk) disable iff (rst)
    (handshake && req_i.dest_wr) |-> rsp_o.old_preg == exp_rsp.old_preg)
    else report_mismatch("old_preg", 32'($sampled(rsp_o.old_preg)), 32'($sampled(exp_rsp.old_preg)));

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    rename_req_t r;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    cdb_i       = '0;
    retire_i    = '0;
    flush_i     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    // Identity map straight out of reset.
    for (int i = 0; i < NUM_AREGS; i++) begin
      send(make_req(i, NUM_AREGS - 1 - i, i, 1'b0), '0, 1'b0);
    end
    // Random renames with broadcasts and retirement.
    for (int n = 0; n < N_RAND; n++) begin
      r = rand_req(take_bits(2) != 0);
      send(r, make_cdb(take_bits(1) != 0, m_map[AREG_W'(take_bits(AREG_W))]),
           (rob_q.size() >= 16) || (take_bits(1) != 0));
    end
    // Bypass and same cycle rename on register 5 and 9.
    send(make_req(1, 2, 5, 1'b1), '0, 1'b0);
    send(make_req(5, 5, 0, 1'b0), '0, 1'b0);                 // Not ready yet.
    send(make_req(5, 3, 0, 1'b0), make_cdb(1'b1, m_map[5]), 1'b0);  // Woken this cycle.
    send(make_req(5, 3, 0, 1'b0), '0, 1'b0);                 // Ready from the table.
    send(make_req(2, 3, 9, 1'b1), '0, 1'b0);
    send(make_req(9, 9, 9, 1'b1), make_cdb(1'b1, m_map[9]), 1'b0);
    send(make_req(9, 4, 0, 1'b0), '0, 1'b0);                 // Rename won.
    // Drain the ROB, then take every free tag.
    while (rob_q.size() > 0) begin
      drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
    end
    repeat (FREE_DEPTH) send(rand_req(1'b1), '0, 1'b0);
    r = rand_req(1'b1);
    repeat (3) drive_cycle(1'b1, r, '0, 1'b0, 1'b0);  // Stalled on empty list.
    send(r, '0, 1'b1);  // One retire frees the tag it gets.
    // Some commits before the flush.
    repeat (5) drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
    repeat (4) send(rand_req(1'b1), make_cdb(1'b1, m_map[AREG_W'(take_bits(AREG_W))]), 1'b0);
    r = rand_req(1'b1);
    drive_cycle(1'b1, r, '0, 1'b1, 1'b1);   // Flush with an oldest retire.
    drive_cycle(1'b1, r, '0, 1'b0, 1'b0);   // Recovery cycle.
    for (int i = 0; i < NUM_AREGS; i++) begin
      send(make_req(i, (i + 7) % NUM_AREGS, i, 1'b0), '0, 1'b0);
    end
    repeat (N_AFTER) send(rand_req(1'b1), '0, 1'b0);
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
    $display("Summary: %0d requests accepted, %0d errors", acc_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* rename_unit.f */
src/rename_pkg.sv
src/map_table.sv
src/arch_map.sv
src/free_list.sv
src/free_count.sv
src/rename_ctrl.sv
src/rename_unit.sv
dv/tb_rename_unit.sv

/* Makefile */
# Verilator build and run for the rename stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= rename_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Test FAILED, see $(LOG)"; exit 1; }
	@echo "Test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
